/* flist.f */
+incdir+common
+incdir+tests
common/fpAddSubPkg.sv
align/fpOperandSwap.sv
align/fpAlignShift.sv
source/fpMantissaAdder.sv
normalize/fpNormalizer.sv
normalize/fpRounder.sv
source/fpAddSub.sv
tests/fpAddSubTb.sv

/* Bender.yml */
package:
  name: fpAddSub

sources:
  - include_dirs:
      - common
    files:
      - common/fpAddSubPkg.sv
      - align/fpOperandSwap.sv
      - align/fpAlignShift.sv
      - source/fpMantissaAdder.sv
      - normalize/fpNormalizer.sv
      - normalize/fpRounder.sv
      - source/fpAddSub.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/fpAddSubTb.sv

/* tests/fpAddSubModel.svh */
`ifndef FPADDSUB_MODEL_SVH
`define FPADDSUB_MODEL_SVH

// Exact sum on wide integers, one rounding at the end
function automatic void modelAddSub(
	input fpAddSubPkg::fpHalfT opA,
	input fpAddSubPkg::fpHalfT opB,
	input logic opSub,
	output fpAddSubPkg::fpHalfT res,
	output fpAddSubPkg::fpFlagsT flg
);
	longint sigA, sigB, total, mag, kept, rem, half;
	int expA, expB, minExp, msb, expOut;
	logic signOut;
	res = '0;
	flg = '0;
	if (opA.exp == `FP_EXP_MAX || opB.exp == `FP_EXP_MAX) begin
		res = `FP_QNAN;                          // Inf or NaN anywhere
		flg.invalid = 1'b1;
		return;
	end
	expA = opA.exp;
	expB = opB.exp;
	minExp = (expA < expB) ? expA : expB;
	sigA = longint'({1'b1, opA.frac}) << (expA - minExp);   // Both on the smaller scale
	sigB = longint'({1'b1, opB.frac}) << (expB - minExp);
	if (opA.sign)
		sigA = -sigA;
	if (opB.sign ^ opSub)
		sigB = -sigB;
	total = sigA + sigB;
	if (total == 0)
		return;                                  // Exact cancellation is +0
	signOut = (total < 0);
	mag = signOut ? -total : total;
	msb = 0;
	for (int i = 0; i < 63; i++) begin
		if (mag[i])
			msb = i;
	end
	expOut = msb + minExp - `FP_MAN_W;           // Biased exponent of leading one
	rem = 0;
	if (msb > `FP_MAN_W) begin
		kept = mag >> (msb - `FP_MAN_W);
		rem = mag - (kept << (msb - `FP_MAN_W));
		half = longint'(1) << (msb - `FP_MAN_W - 1);
		if (rem > half || (rem == half && kept[0]))
			kept++;                              // Nearest, ties to even
	end else begin
		kept = mag << (`FP_MAN_W - msb);
	end
	if (kept == (longint'(1) << `FP_SIG_W)) begin
		kept = kept >> 1;                        // Round carried past hidden one
		expOut++;
	end
	res.sign = signOut;
	if (expOut >= `FP_EXP_MAX) begin
		res.exp = '1;
		flg.overflow = 1'b1;
		flg.inexact = 1'b1;
	end else if (expOut <= 0) begin
		flg.underflow = 1'b1;                    // Flushed, sign kept
		flg.inexact = 1'b1;
	end else begin
		res.exp = `FP_EXP_W'(expOut);
		res.frac = kept[`FP_MAN_W-1:0];
		flg.inexact = (rem != 0);
	end
endfunction

`endif

/* tests/fpAddSubTb.sv */
`include "fpAddSub_config.svh"

module fpAddSubTb;

	localparam int ResetCycles = 10;
	localparam int Latency = 5;
	localparam int PhaseCount [6] = '{2000, 300, 300, 100, 100, 200};
	localparam int TotalVectors = 2000 + 300 + 300 + 100 + 100 + 200;
	localparam int TimeoutCycles = ResetCycles + TotalVectors + Latency + 50;
	localparam fpAddSubPkg::fpHalfT IdleOp = 16'h3C00;   // 1.0, never zero exponent

	logic clk;
	logic rst;
	fpAddSubPkg::fpHalfT a;
	fpAddSubPkg::fpHalfT b;
	logic sub;
	fpAddSubPkg::fpHalfT result;
	fpAddSubPkg::fpFlagsT flags;

	fpAddSubPkg::fpHalfT expResQ [$];       // Expected, popped five cycles later
	fpAddSubPkg::fpFlagsT expFlagsQ [$];
	int resultErrors = 0;
	int flagErrors = 0;
	int cycleCount = 0;
	int seedVal;

	`include "fpAddSubModel.svh"

	fpAddSub dut_i (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.sub(sub),
		.result(result),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Cycle limit
	initial begin
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount >= TimeoutCycles) begin
				$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
				$display("Errors found");
				$finish;
			end
		end
	end

	task automatic checkResult(input fpAddSubPkg::fpHalfT expected, input fpAddSubPkg::fpHalfT actual);
		if (actual !== expected) begin
			resultErrors++;
			$display("Fail at %0t: result expected %h, got %h", $time, expected, actual);
		end
	endtask

	task automatic checkFlags(input fpAddSubPkg::fpFlagsT expected, input fpAddSubPkg::fpFlagsT actual);
		if (actual !== expected) begin
			flagErrors++;
			$display("Fail at %0t: flags expected %b, got %b", $time, expected, actual);
		end
	endtask

	// One falling edge, check what is due, then drive
	task automatic stepCycle(input fpAddSubPkg::fpHalfT nextA, input fpAddSubPkg::fpHalfT nextB,
			input logic nextSub, input logic holdReset,
			input fpAddSubPkg::fpHalfT expRes, input fpAddSubPkg::fpFlagsT expFlags);
		@(negedge clk);
		if (expResQ.size() == Latency) begin
			checkResult(expResQ.pop_front(), result);
			checkFlags(expFlagsQ.pop_front(), flags);
		end
		rst = holdReset;
		a = nextA;
		b = nextB;
		sub = nextSub;
		expResQ.push_back(expRes);
		expFlagsQ.push_back(expFlags);
	endtask

	function automatic fpAddSubPkg::fpHalfT randNormal();
		fpAddSubPkg::fpHalfT v;
		v.sign = 1'($urandom);
		v.exp = `FP_EXP_W'(1 + $urandom % 30);   // 1..30 only
		v.frac = `FP_MAN_W'($urandom);
		return v;
	endfunction

	// Operand pair for each stimulus phase
	task automatic genVector(input int kind, output fpAddSubPkg::fpHalfT opA,
			output fpAddSubPkg::fpHalfT opB, output logic opSub);
		fpAddSubPkg::fpHalfT tmp;
		int expB;
		opA = randNormal();
		opB = randNormal();
		opSub = 1'($urandom);
		case (kind)
			1: begin                                // Cancellation
				opB = opA;
				opB.sign = opA.sign ^ opSub ^ 1'b1;
				expB = int'(opA.exp) + int'($urandom % 3) - 1;
				if (expB >= 1 && expB <= 30)
					opB.exp = `FP_EXP_W'(expB);
				if ($urandom % 4 != 0)
					opB.frac = opA.frac ^ `FP_MAN_W'($urandom % 8);
			end
			2: begin                                // Wide gap, gap 11 can tie
				opA.exp = `FP_EXP_W'(22 + $urandom % 9);
				expB = int'(opA.exp) - 11 - int'($urandom % 11);
				opB.exp = `FP_EXP_W'((expB < 1) ? 1 : expB);
				if ($urandom % 4 == 0)
					opB.frac = '0;
				if ($urandom % 2 == 1) begin
					tmp = opA;
					opA = opB;
					opB = tmp;
				end
			end
			3: begin                                // Overflow
				opA.exp = 5'd30;
				opB.exp = 5'd30;
				opB.sign = opA.sign ^ opSub;
			end
			4: begin                                // Underflow by cancellation
				opA.exp = `FP_EXP_W'(1 + $urandom % 2);
				opB = opA;
				opB.sign = opA.sign ^ opSub ^ 1'b1;
				opB.frac = opA.frac ^ `FP_MAN_W'(1 + $urandom % 15);
			end
			5: begin                                // Inf or NaN on one side or both
				expB = $urandom % 3;
				if (expB != 1)
					opA.exp = '1;
				if (expB != 0)
					opB.exp = '1;
				if ($urandom % 4 == 0)
					opA.frac = '0;
			end
			default: ;
		endcase
	endtask

	initial begin
		fpAddSubPkg::fpHalfT opA;
		fpAddSubPkg::fpHalfT opB;
		fpAddSubPkg::fpHalfT expRes;
		fpAddSubPkg::fpFlagsT expFlags;
		logic opSub;
		rst = 1'b1;
		a = IdleOp;
		b = IdleOp;
		sub = 1'b0;
		seedVal = 61087;
		void'($urandom(seedVal));
		// Edge at time 4 already sees reset
		repeat (ResetCycles - 1)
			stepCycle(IdleOp, IdleOp, 1'b0, 1'b1, '0, '0);
		for (int k = 0; k < 6; k++) begin
			repeat (PhaseCount[k]) begin
				genVector(k, opA, opB, opSub);
				modelAddSub(opA, opB, opSub, expRes, expFlags);
				stepCycle(opA, opB, opSub, 1'b0, expRes, expFlags);
			end
		end
		repeat (Latency)
			stepCycle(IdleOp, IdleOp, 1'b0, 1'b0, '0, '0);   // Drain, never checked
		$display("Result errors: %0d, flag errors: %0d", resultErrors, flagErrors);
		if (resultErrors + flagErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* source/fpAddSub.sv */
`include "fpAddSub_config.svh"

module fpAddSub (
	input  logic clk,
	input  logic rst,
	input  fpAddSubPkg::fpHalfT a,
	input  fpAddSubPkg::fpHalfT b,
	input  logic sub,                      // 1 gives a - b
	output fpAddSubPkg::fpHalfT result,
	output fpAddSubPkg::fpFlagsT flags
);

	// Payloads between the five registered stages
	fpAddSubPkg::swapStageT swapStage;
	fpAddSubPkg::alignStageT alignStage;
	fpAddSubPkg::sumStageT sumStage;
	fpAddSubPkg::normStageT normStage;

	// Stage 1, classify and order
	fpOperandSwap operandSwap_i (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.sub(sub),
		.swapOut(swapStage)
	);

	// Stage 2, align smaller operand
	fpAlignShift alignShift_i (
		.clk(clk),
		.rst(rst),
		.swapIn(swapStage),
		.alignOut(alignStage)
	);

	// Stage 3
	fpMantissaAdder mantissaAdder_i (
		.clk(clk),
		.rst(rst),
		.alignIn(alignStage),
		.sumOut(sumStage)
	);

	// Stage 4
	fpNormalizer normalizer_i (
		.clk(clk),
		.rst(rst),
		.sumIn(sumStage),
		.normOut(normStage)
	);

	// Stage 5, round and pack
	fpRounder rounder_i (
		.clk(clk),
		.rst(rst),
		.normIn(normStage),
		.result(result),
		.flags(flags)
	);

endmodule

/* normalize/fpRounder.sv */
`include "fpAddSub_config.svh"

module fpRounder (
	input  logic clk,
	input  logic rst,
	input  fpAddSubPkg::normStageT normIn,
	output fpAddSubPkg::fpHalfT result,
	output fpAddSubPkg::fpFlagsT flags
);

	logic guard;
	logic roundBit;
	logic sticky;
	logic roundUp;
	logic [`FP_SIG_W:0] sigRnd;                // Room for rounding carry
	logic signed [`FP_EXP_W+1:0] expRnd;       // Holds max exponent plus one
	logic [`FP_WIDTH-1:0] packedNum;
	fpAddSubPkg::fpHalfT resNext;
	fpAddSubPkg::fpFlagsT flagsNext;

	always_comb begin
		guard = normIn.sig[2];
		roundBit = normIn.sig[1];
		sticky = normIn.sig[0];

		// Nearest, ties to even on fraction LSB
		roundUp = guard & (roundBit | sticky | normIn.sig[`FP_GRS_W]);
		sigRnd = {1'b0, normIn.sig[`FP_SIG_W+`FP_GRS_W-1:`FP_GRS_W]} + roundUp;

		// Carry out of rounding bumps the exponent, fraction is then zero
		expRnd = normIn.exp + $signed({1'b0, sigRnd[`FP_SIG_W]});

		packedNum = {normIn.sign, expRnd[`FP_EXP_W-1:0], sigRnd[`FP_MAN_W-1:0]};

		flagsNext = '0;
		if (normIn.special) begin
			resNext = `FP_QNAN;                    // Any Inf or NaN input
			flagsNext.invalid = 1'b1;
		end else if (normIn.zero) begin
			resNext = '0;                          // Cancellation gives +0
		end else if (expRnd >= `FP_EXP_MAX) begin
			resNext.sign = normIn.sign;            // Signed infinity
			resNext.exp = '1;
			resNext.frac = '0;
			flagsNext.overflow = 1'b1;
			flagsNext.inexact = 1'b1;
		end else if (expRnd <= 0) begin
			resNext.sign = normIn.sign;            // Flush to signed zero
			resNext.exp = '0;
			resNext.frac = '0;
			flagsNext.underflow = 1'b1;
			flagsNext.inexact = 1'b1;
		end else begin
			resNext = packedNum;
			flagsNext.inexact = guard | roundBit | sticky;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			flags <= '0;
		end else begin
			result <= resNext;
			flags <= flagsNext;
		end
	end

endmodule

/* normalize/fpNormalizer.sv */
`include "fpAddSub_config.svh"

module fpNormalizer (
	input  logic clk,
	input  logic rst,
	input  fpAddSubPkg::sumStageT sumIn,
	output fpAddSubPkg::normStageT normOut
);

	localparam int ExtW = `FP_SIG_W + `FP_GRS_W;   // Sum without carry
	localparam int LzW = $clog2(ExtW);

	logic carry;
	logic [ExtW-1:0] body;
	logic [LzW-1:0] lz;                    // Leading zeros of body
	fpAddSubPkg::normStageT normNext;

	always_comb begin
		carry = sumIn.sum[ExtW];
		body = sumIn.sum[ExtW-1:0];

		// Highest set bit wins, it is visited last
		lz = '0;
		for (int i = 0; i < ExtW; i++) begin
			if (body[i])
				lz = LzW'(ExtW - 1 - i);
		end

		if (carry) begin
			// One right, lost bit joins sticky
			normNext.sig = {sumIn.sum[ExtW:2], |sumIn.sum[1:0]};
			normNext.exp = {1'b0, sumIn.exp} + 1'b1;
		end else begin
			normNext.sig = body << lz;
			normNext.exp = {1'b0, sumIn.exp} - {{(`FP_EXP_W+1-LzW){1'b0}}, lz};   // Can go <= 0
		end

		normNext.zero = ~|sumIn.sum;           // Exact cancellation
		normNext.sign = sumIn.sign;
		normNext.special = sumIn.special;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			normOut <= '0;
			normOut.zero <= 1'b1;              // Empty slot rounds to +0 with no flags
		end else begin
			normOut <= normNext;
		end
	end

endmodule

/* source/fpMantissaAdder.sv */
`include "fpAddSub_config.svh"

module fpMantissaAdder (
	input  logic clk,
	input  logic rst,
	input  fpAddSubPkg::alignStageT alignIn,
	output fpAddSubPkg::sumStageT sumOut
);

	logic [`FP_SIG_W+`FP_GRS_W:0] bigExt;     // Zero G R S, extra carry bit
	logic [`FP_SIG_W+`FP_GRS_W:0] smallExt;
	fpAddSubPkg::sumStageT sumNext;

	always_comb begin
		bigExt = {1'b0, alignIn.bigSig, `FP_GRS_W'(0)};
		smallExt = {1'b0, alignIn.smallExt};

		// Larger first, so the difference stays positive
		if (alignIn.effSub)
			sumNext.sum = bigExt - smallExt;
		else
			sumNext.sum = bigExt + smallExt;   // May carry into top bit

		sumNext.sign = alignIn.sign;
		sumNext.exp = alignIn.exp;
		sumNext.special = alignIn.special;
	end

	always_ff @(posedge clk) begin
		if (rst)
			sumOut <= '0;
		else
			sumOut <= sumNext;
	end

endmodule

/* align/fpAlignShift.sv */
`include "fpAddSub_config.svh"

module fpAlignShift (
	input  logic clk,
	input  logic rst,
	input  fpAddSubPkg::swapStageT swapIn,
	output fpAddSubPkg::alignStageT alignOut
);

	// Significand plus guard and round
	localparam int GrW = `FP_SIG_W + `FP_GRS_W - 1;

	logic [GrW-1:0] smallGr;
	logic [2*GrW-1:0] wide;      // Lower half catches shifted-out bits
	fpAddSubPkg::alignStageT alignNext;

	always_comb begin
		smallGr = {swapIn.smallSig, 2'b00};
		wide = {smallGr, {GrW{1'b0}}} >> swapIn.shift;

		// Anything past round folds into sticky
		alignNext.smallExt = {wide[2*GrW-1:GrW], |wide[GrW-1:0]};

		alignNext.sign = swapIn.sign;
		alignNext.effSub = swapIn.effSub;
		alignNext.exp = swapIn.exp;
		alignNext.bigSig = swapIn.bigSig;
		alignNext.special = swapIn.special;
	end

	always_ff @(posedge clk) begin
		if (rst)
			alignOut <= '0;
		else
			alignOut <= alignNext;
	end

endmodule

/* align/fpOperandSwap.sv */
`include "fpAddSub_config.svh"

module fpOperandSwap (
	input  logic clk,
	input  logic rst,
	input  fpAddSubPkg::fpHalfT a,
	input  fpAddSubPkg::fpHalfT b,
	input  logic sub,
	output fpAddSubPkg::swapStageT swapOut
);

	logic bSign;                     // Sign of b as it enters the sum
	logic aBigger;                   // |a| >= |b|
	logic [`FP_EXP_W-1:0] expDiff;
	fpAddSubPkg::swapStageT swapNext;

	always_comb begin
		bSign = b.sign ^ sub;
		// Exponent above fraction, so one compare orders magnitudes
		aBigger = {a.exp, a.frac} >= {b.exp, b.frac};

		swapNext.special = (&a.exp) | (&b.exp);   // Inf or NaN on either side
		swapNext.effSub = a.sign ^ bSign;
		swapNext.sign = aBigger ? a.sign : bSign;
		swapNext.exp = aBigger ? a.exp : b.exp;
		swapNext.bigSig = aBigger ? {1'b1, a.frac} : {1'b1, b.frac};
		swapNext.smallSig = aBigger ? {1'b1, b.frac} : {1'b1, a.frac};

		// Never negative after ordering
		expDiff = aBigger ? (a.exp - b.exp) : (b.exp - a.exp);

		// Past this everything lands in sticky
		if (expDiff > `FP_EXP_W'(`FP_SIG_W + `FP_GRS_W))
			swapNext.shift = `FP_EXP_W'(`FP_SIG_W + `FP_GRS_W);
		else
			swapNext.shift = expDiff;
	end

	always_ff @(posedge clk) begin
		if (rst)
			swapOut <= '0;
		else
			swapOut <= swapNext;
	end

endmodule

/* common/fpAddSubPkg.sv */
`include "fpAddSub_config.svh"

package fpAddSubPkg;

	// IEEE half, MSB first
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_MAN_W-1:0] frac;
	} fpHalfT;

	// Exception flags, no divide-by-zero in add/sub
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} fpFlagsT;

	// Swap -> align
	typedef struct packed {
		logic sign;                          // Sign of larger operand
		logic effSub;                        // Magnitudes get subtracted
		logic [`FP_EXP_W-1:0] exp;           // Larger exponent
		logic [`FP_SIG_W-1:0] bigSig;
		logic [`FP_SIG_W-1:0] smallSig;
		logic [`FP_EXP_W-1:0] shift;         // Saturated alignment shift
		logic special;                       // Inf or NaN seen
	} swapStageT;

	// Align -> add
	typedef struct packed {
		logic sign;
		logic effSub;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_SIG_W-1:0] bigSig;
		logic [`FP_SIG_W+`FP_GRS_W-1:0] smallExt;   // Shifted, with G R S
		logic special;
	} alignStageT;

	// Add -> normalize
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_SIG_W+`FP_GRS_W:0] sum;   // Top bit is carry out
		logic special;
	} sumStageT;

	// Normalize -> round
	typedef struct packed {
		logic sign;
		logic signed [`FP_EXP_W:0] exp;      // May drop to zero or below
		logic [`FP_SIG_W+`FP_GRS_W-1:0] sig; // Hidden one, fraction, G R S
		logic zero;
		logic special;
	} normStageT;

endpackage

/* common/fpAddSub_config.svh */
`ifndef FPADDSUB_CONFIG_SVH
`define FPADDSUB_CONFIG_SVH

// Half precision field widths
`define FP_EXP_W 5
`define FP_MAN_W 10
`define FP_WIDTH 16

// Significand with hidden one
`define FP_SIG_W 11

// Guard, round and sticky bits below the LSB
`define FP_GRS_W 3

// All-ones exponent, marks Inf and NaN
`define FP_EXP_MAX 31

// Canonical quiet NaN
`define FP_QNAN 16'h7E00

`endif
